//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench, log in $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_gloves_keeper \
		-f project.f -o sim_gloves_keeper
	./obj_dir/sim_gloves_keeper | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- project.f
+incdir+verification
rtl/gk_pkg.sv
rtl/phase_timer.sv
rtl/shot_target.sv
rtl/crosshair_overlay.sv
rtl/gk_round_fsm.sv
rtl/gloves_keeper_top.sv
verification/gloves_keeper_sva.sv
verification/tb_gloves_keeper.sv

//--- rtl/crosshair_overlay.sv
// crosshair_overlay: one-cycle VGA stream register that paints the target square
`timescale 1ns/1ns

module crosshair_overlay (
    input  logic              clk,
    input  logic              rst,
    input  logic [9:0]        target_x,
    input  logic [9:0]        target_y,
    input  gk_pkg::paint_t    paint_mode,
    input  logic [10:0]       vga_in_hcount,
    input  logic [10:0]       vga_in_vcount,
    input  logic              vga_in_hsync,
    input  logic              vga_in_vsync,
    input  logic              vga_in_hblnk,
    input  logic              vga_in_vblnk,
    input  logic [11:0]       vga_in_rgb,
    output logic [10:0]       vga_out_hcount,
    output logic [10:0]       vga_out_vcount,
    output logic              vga_out_hsync,
    output logic              vga_out_vsync,
    output logic              vga_out_hblnk,
    output logic              vga_out_vblnk,
    output logic [11:0]       vga_out_rgb
);

    logic [10:0] square_x_hi;
    logic [10:0] square_y_hi;
    logic        in_square;
    logic [11:0] rgb_nxt;

    assign square_x_hi = {1'b0, target_x} + gk_pkg::glove_span[10:0];
    assign square_y_hi = {1'b0, target_y} + gk_pkg::glove_span[10:0];

    // only the visible part of the square gets painted
    assign in_square = (vga_in_hcount >= {1'b0, target_x}) && (vga_in_hcount <= square_x_hi) &&
                       (vga_in_vcount >= {1'b0, target_y}) && (vga_in_vcount <= square_y_hi) &&
                       (vga_in_hcount <= gk_pkg::screen_x_max[10:0]) &&
                       (vga_in_vcount <= gk_pkg::screen_y_max[10:0]);

    always_comb begin
        rgb_nxt = vga_in_rgb;
        if (in_square) begin
            case (paint_mode)
                gk_pkg::paint_aim:  rgb_nxt = gk_pkg::rgb_aim;
                gk_pkg::paint_goal: rgb_nxt = gk_pkg::rgb_goal;
                gk_pkg::paint_save: rgb_nxt = gk_pkg::rgb_save;
                default:            rgb_nxt = vga_in_rgb;
            endcase
        end
    end

    // timing and colour share one register stage
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out_hcount <= '0;
            vga_out_vcount <= '0;
            vga_out_hsync  <= 1'b0;
            vga_out_vsync  <= 1'b0;
            vga_out_hblnk  <= 1'b0;
            vga_out_vblnk  <= 1'b0;
            vga_out_rgb    <= '0;
        end else begin
            vga_out_hcount <= vga_in_hcount;
            vga_out_vcount <= vga_in_vcount;
            vga_out_hsync  <= vga_in_hsync;
            vga_out_vsync  <= vga_in_vsync;
            vga_out_hblnk  <= vga_in_hblnk;
            vga_out_vblnk  <= vga_in_vblnk;
            vga_out_rgb    <= rgb_nxt;
        end
    end

endmodule

//--- rtl/gk_pkg.sv
// goalkeeper constants: screen limits, glove square, edge lines, colours, phase timing, paint type
package gk_pkg;

    // visible screen area
    localparam int unsigned screen_x_max = 1023;
    localparam int unsigned screen_y_max = 767;

    // side of the target square in pixels
    localparam int unsigned glove_span = 100;

    // a shot landing exactly on one of these lines never counts
    localparam int unsigned edge_x_lo = 0;
    localparam int unsigned edge_x_hi = 1000;
    localparam int unsigned edge_y_lo = 0;
    localparam int unsigned edge_y_hi = 738;

    // phase lengths at 65 MHz
    localparam int unsigned countdown_cycles_def = 32_500_000; // about 0.5 s
    localparam int unsigned show_cycles_def      = 16_250_000; // about 0.25 s
    localparam int unsigned timer_width          = 26;

    // 12-bit rgb, 4 bits per channel
    localparam logic [11:0] rgb_aim  = 12'h0_0_f;
    localparam logic [11:0] rgb_goal = 12'hf_0_0;
    localparam logic [11:0] rgb_save = 12'h0_f_0;

    typedef enum logic [1:0] {
        paint_off,
        paint_aim,
        paint_goal,
        paint_save
    } paint_t;

endpackage

//--- rtl/gk_round_fsm.sv
// gk_round_fsm: keeper round FSM with phase timer requests, paint mode and registered status
`timescale 1ns/1ns

module gk_round_fsm (
    input  logic           clk,
    input  logic           rst,
    input  logic           keeper_active,
    input  logic           enemy_shot,
    input  logic           timer_done,
    input  logic           is_save,
    output logic           timer_start,
    output logic           timer_len_sel,
    output logic           capture,
    output logic           clear,
    output gk_pkg::paint_t paint_mode,
    output logic           is_scored,
    output logic           round_done,
    output logic           end_gk
);

    typedef enum logic [2:0] {
        st_idle,
        st_engage,
        st_countdown,
        st_result,
        st_goal,
        st_miss,
        st_terminate
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            is_scored  <= 1'b0;
            round_done <= 1'b0;
            end_gk     <= 1'b0;
        end else begin
            state      <= state_nxt;
            // taken from the next state so status lines up with the state register
            is_scored  <= (state_nxt == st_goal);
            round_done <= (state_nxt == st_goal) || (state_nxt == st_miss);
            end_gk     <= (state == st_terminate) && timer_done;
        end
    end

    always_comb begin
        state_nxt     = state;
        timer_start   = 1'b0;
        timer_len_sel = 1'b0;
        clear         = 1'b0;
        case (state)
            st_idle: begin
                if (keeper_active)
                    state_nxt = st_engage;
            end
            st_engage: begin
                if (!keeper_active) begin // keeper phase left before a shot
                    state_nxt = st_idle;
                    clear     = 1'b1;
                end else if (enemy_shot) begin
                    state_nxt     = st_countdown;
                    timer_start   = 1'b1;
                    timer_len_sel = 1'b1;
                end
            end
            st_countdown: begin
                if (timer_done)
                    state_nxt = st_result;
            end
            st_result: begin
                state_nxt   = is_save ? st_miss : st_goal;
                timer_start = 1'b1;
            end
            st_goal, st_miss: begin
                if (timer_done) begin
                    state_nxt   = st_terminate;
                    timer_start = 1'b1;
                end
            end
            st_terminate: begin
                if (timer_done) begin
                    state_nxt = st_idle;
                    clear     = 1'b1;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    assign capture = (state == st_engage); // follow the shot until it is fired

    always_comb begin
        case (state)
            st_countdown: paint_mode = gk_pkg::paint_aim;
            st_goal:      paint_mode = gk_pkg::paint_goal;
            st_miss:      paint_mode = gk_pkg::paint_save;
            default:      paint_mode = gk_pkg::paint_off;
        endcase
    end

endmodule

//--- rtl/gloves_keeper_top.sv
// gloves_keeper_top: goalkeeper side with round FSM, phase timer, shot target and overlay
`timescale 1ns/1ns

module gloves_keeper_top #(
    parameter int unsigned COUNTDOWN_CYCLES = gk_pkg::countdown_cycles_def,
    parameter int unsigned SHOW_CYCLES      = gk_pkg::show_cycles_def
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        keeper_active,
    input  logic        enemy_shot,
    input  logic [9:0]  shot_x,
    input  logic [9:0]  shot_y,
    input  logic [11:0] glove_x,
    input  logic [11:0] glove_y,
    input  logic [10:0] vga_in_hcount,
    input  logic [10:0] vga_in_vcount,
    input  logic        vga_in_hsync,
    input  logic        vga_in_vsync,
    input  logic        vga_in_hblnk,
    input  logic        vga_in_vblnk,
    input  logic [11:0] vga_in_rgb,
    output logic        is_scored,
    output logic        round_done,
    output logic        end_gk,
    output logic [10:0] vga_out_hcount,
    output logic [10:0] vga_out_vcount,
    output logic        vga_out_hsync,
    output logic        vga_out_vsync,
    output logic        vga_out_hblnk,
    output logic        vga_out_vblnk,
    output logic [11:0] vga_out_rgb
);

    logic           timer_start;
    logic           timer_len_sel;
    logic           timer_done;
    logic           capture;
    logic           clear;
    logic           is_save;
    logic [9:0]     target_x;
    logic [9:0]     target_y;
    gk_pkg::paint_t paint_mode;

    gk_round_fsm u_fsm (
        .clk,
        .rst,
        .keeper_active,
        .enemy_shot,
        .timer_done,
        .is_save,
        .timer_start,
        .timer_len_sel,
        .capture,
        .clear,
        .paint_mode,
        .is_scored,
        .round_done,
        .end_gk
    );

    phase_timer #(
        .COUNTDOWN_CYCLES(COUNTDOWN_CYCLES),
        .SHOW_CYCLES     (SHOW_CYCLES)
    ) u_timer (
        .clk,
        .rst,
        .timer_start,
        .timer_len_sel,
        .timer_done
    );

    shot_target u_target (
        .clk,
        .rst,
        .capture,
        .clear,
        .shot_x,
        .shot_y,
        .glove_x,
        .glove_y,
        .target_x,
        .target_y,
        .is_save
    );

    crosshair_overlay u_overlay (
        .clk,
        .rst,
        .target_x,
        .target_y,
        .paint_mode,
        .vga_in_hcount,
        .vga_in_vcount,
        .vga_in_hsync,
        .vga_in_vsync,
        .vga_in_hblnk,
        .vga_in_vblnk,
        .vga_in_rgb,
        .vga_out_hcount,
        .vga_out_vcount,
        .vga_out_hsync,
        .vga_out_vsync,
        .vga_out_hblnk,
        .vga_out_vblnk,
        .vga_out_rgb
    );

endmodule

//--- rtl/phase_timer.sv
// phase_timer: restartable cycle counter flagging the last cycle of a countdown or show phase
`timescale 1ns/1ns

module phase_timer #(
    parameter int unsigned COUNTDOWN_CYCLES = gk_pkg::countdown_cycles_def,
    parameter int unsigned SHOW_CYCLES      = gk_pkg::show_cycles_def
) (
    input  logic clk,
    input  logic rst,
    input  logic timer_start,
    input  logic timer_len_sel, // 1 = countdown, 0 = show
    output logic timer_done
);

    localparam int unsigned CD_LAST   = COUNTDOWN_CYCLES - 1;
    localparam int unsigned SHOW_LAST = SHOW_CYCLES - 1;

    logic [gk_pkg::timer_width-1:0] count;
    logic [gk_pkg::timer_width-1:0] count_last;
    logic                           running;
    logic                           len_sel_q;

    assign count_last = len_sel_q ? CD_LAST[gk_pkg::timer_width-1:0]
                                  : SHOW_LAST[gk_pkg::timer_width-1:0];

    // first phase cycle sees count == 0
    assign timer_done = running && (count == count_last);

    always_ff @(posedge clk) begin
        if (rst) begin
            running   <= 1'b0;
            count     <= '0;
            len_sel_q <= 1'b0;
        end else if (timer_start) begin // restart wins over done
            running   <= 1'b1;
            count     <= '0;
            len_sel_q <= timer_len_sel;
        end else if (timer_done) begin
            running <= 1'b0;
        end else if (running) begin
            count <= count + 1'b1;
        end
    end

endmodule

//--- rtl/shot_target.sv
// shot_target: shot position capture with y clamp, and the save or goal judgement
`timescale 1ns/1ns

module shot_target (
    input  logic        clk,
    input  logic        rst,
    input  logic        capture,
    input  logic        clear,
    input  logic [9:0]  shot_x,
    input  logic [9:0]  shot_y,
    input  logic [11:0] glove_x,
    input  logic [11:0] glove_y,
    output logic [9:0]  target_x,
    output logic [9:0]  target_y,
    output logic        is_save
);

    logic [11:0] square_x_hi;
    logic [11:0] square_y_hi;
    logic        on_edge;
    logic        glove_inside;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            target_x <= '0;
            target_y <= '0;
        end else if (capture) begin
            target_x <= shot_x; // 10 bits never exceed the last column
            if (shot_y > gk_pkg::screen_y_max[9:0])
                target_y <= gk_pkg::screen_y_max[9:0];
            else
                target_y <= shot_y;
        end
    end

    assign square_x_hi = {2'b00, target_x} + gk_pkg::glove_span[11:0];
    assign square_y_hi = {2'b00, target_y} + gk_pkg::glove_span[11:0];

    assign on_edge = (target_x == gk_pkg::edge_x_lo[9:0]) ||
                     (target_x == gk_pkg::edge_x_hi[9:0]) ||
                     (target_y == gk_pkg::edge_y_lo[9:0]) ||
                     (target_y == gk_pkg::edge_y_hi[9:0]);

    // square bounds are inclusive on both sides
    assign glove_inside = (glove_x >= {2'b00, target_x}) && (glove_x <= square_x_hi) &&
                          (glove_y >= {2'b00, target_y}) && (glove_y <= square_y_hi);

    assign is_save = on_edge || glove_inside;

endmodule

//--- verification/gloves_keeper_sva.sv
// gloves_keeper_sva: status output assertions, bound into gk_round_fsm
`timescale 1ns/1ns

module gloves_keeper_sva (
    input logic clk,
    input logic rst,
    input logic is_scored,
    input logic round_done,
    input logic end_gk
);

    a_end_gk_pulse: assert property (@(posedge clk) disable iff (rst) end_gk |=> !end_gk)
        else $error("end_gk held for more than one cycle");

    // a goal is always shown as a finished round
    a_scored_in_round: assert property (@(posedge clk) disable iff (rst) is_scored |-> round_done)
        else $error("is_scored high without round_done");

    a_end_apart: assert property (@(posedge clk) disable iff (rst) !(end_gk && round_done))
        else $error("end_gk high together with round_done");

endmodule

bind gk_round_fsm gloves_keeper_sva u_sva (
    .clk,
    .rst,
    .is_scored,
    .round_done,
    .end_gk
);

//--- verification/gk_tests.svh
// directed test tasks for gloves_keeper_top with cycle, pixel, round and error helpers
`ifndef GK_TESTS_SVH
`define GK_TESTS_SVH

task automatic step_cycle();
    @(negedge clk);
endtask

task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    errors++;
endtask

task automatic finish_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors != errs_at_start)
        tests_failed++;
    $display("%-12s finished, %0d errors", name, errors - errs_at_start);
endtask

task automatic drive_pixel(input logic [10:0] h, input logic [10:0] v, input logic [11:0] rgb);
    vga_in_hcount = h;
    vga_in_vcount = v;
    vga_in_hsync  = 1'b0;
    vga_in_vsync  = 1'b0;
    vga_in_hblnk  = 1'b0;
    vga_in_vblnk  = 1'b0;
    vga_in_rgb    = rgb;
endtask

// one full round from IDLE back to IDLE with timing and paint checks
task automatic run_round(input logic [9:0] sx, input logic [9:0] sy,
                         input logic [11:0] gx, input logic [11:0] gy, input bit exp_goal);
    logic [10:0] tx;
    logic [10:0] ty;
    logic [11:0] show_rgb;
    logic [11:0] pix_rgb;
    int          n;
    tx       = {1'b0, sx};
    ty       = (sy > 10'd767) ? 11'd767 : {1'b0, sy}; // target row is clamped
    show_rgb = exp_goal ? gk_pkg::rgb_goal : gk_pkg::rgb_save;
    pix_rgb  = 12'($urandom());
    shot_x        = sx;
    shot_y        = sy;
    glove_x       = gx;
    glove_y       = gy;
    keeper_active = 1'b1;
    step_cycle(); // now in ENGAGE
    enemy_shot = 1'b1;
    step_cycle(); // shot sampled and countdown running
    enemy_shot    = 1'b0;
    keeper_active = 1'b0;
    shot_x        = ~sx; // the captured position must not follow
    shot_y        = ~sy;
    drive_pixel(tx, ty, 12'h5a5);
    step_cycle();
    if (vga_out_rgb !== gk_pkg::rgb_aim)
        report_error($sformatf("aim pixel rgb %h, expected %h", vga_out_rgb, gk_pkg::rgb_aim));
    drive_pixel(tx + 11'd101, ty, pix_rgb);
    step_cycle();
    if (vga_out_rgb !== pix_rgb)
        report_error($sformatf("outside pixel rgb %h, expected %h", vga_out_rgb, pix_rgb));
    n = 2;
    while (!round_done && n < 50) begin
        step_cycle();
        n++;
    end
    if (!round_done) begin
        $display("round_done did not rise within 50 cycles of the shot");
        errors++;
        return;
    end
    if (n != 9)
        report_error($sformatf("round_done rose %0d cycles after the shot, expected 9", n));
    drive_pixel(tx, ty, 12'h5a5);
    n = 0;
    while (round_done && n < 50) begin
        if (is_scored !== exp_goal)
            report_error($sformatf("is_scored %b during result, expected %b", is_scored, exp_goal));
        if (n == 1 && vga_out_rgb !== show_rgb)
            report_error($sformatf("result pixel rgb %h, expected %h", vga_out_rgb, show_rgb));
        step_cycle();
        n++;
    end
    if (round_done) begin
        $display("round_done stayed high for more than 50 cycles");
        errors++;
        return;
    end
    if (n != 6)
        report_error($sformatf("round_done high for %0d cycles, expected 6", n));
    n = 0;
    while (!end_gk && n < 50) begin
        step_cycle();
        n++;
    end
    if (!end_gk) begin
        $display("end_gk did not pulse within 50 cycles of the result display");
        errors++;
        return;
    end
    if (n != 6)
        report_error($sformatf("end_gk came %0d cycles after round_done fell, expected 6", n));
    step_cycle();
    if (end_gk)
        report_error("end_gk high for more than one cycle");
endtask

task automatic test_reset_idle();
    logic [37:0] sent;
    int          start;
    start = errors;
    if (is_scored || round_done || end_gk)
        report_error($sformatf("status after reset %b%b%b, expected 000",
                               is_scored, round_done, end_gk));
    for (int i = 0; i < 16; i++) begin
        sent = 38'({$urandom(), $urandom()});
        {vga_in_hcount, vga_in_vcount, vga_in_hsync, vga_in_vsync,
         vga_in_hblnk, vga_in_vblnk, vga_in_rgb} = sent;
        step_cycle();
        if ({vga_out_hcount, vga_out_vcount, vga_out_hsync, vga_out_vsync,
             vga_out_hblnk, vga_out_vblnk, vga_out_rgb} !== sent)
            report_error($sformatf("vga output differs from input one cycle earlier (%h)", sent));
    end
    finish_test("reset_idle", start);
endtask

task automatic test_goal_round();
    logic [9:0] sx;
    logic [9:0] sy;
    int         start;
    start = errors;
    sx = 10'($urandom_range(900, 1)); // clear of the edge lines
    sy = 10'($urandom_range(700, 1));
    run_round(sx, sy, {2'b00, sx} + 12'd101 + 12'($urandom_range(99)), {2'b00, sy}, 1'b1);
    finish_test("goal_round", start);
endtask

task automatic test_save_round();
    logic [9:0] sx;
    logic [9:0] sy;
    int         start;
    start = errors;
    sx = 10'($urandom_range(900, 1));
    sy = 10'($urandom_range(700, 1));
    run_round(sx, sy, {2'b00, sx} + 12'd50, {2'b00, sy} + 12'd50, 1'b0);
    // right edge line with the glove far off
    run_round(10'd1000, sy, 12'd0, 12'd0, 1'b0);
    finish_test("save_round", start);
endtask

task automatic test_clamp();
    logic [9:0] sx;
    int         start;
    start = errors;
    sx = 10'($urandom_range(900, 1));
    run_round(sx, 10'd900, {2'b00, sx} + 12'd10, 12'd767, 1'b0);
    finish_test("clamp", start);
endtask

task automatic test_overlay();
    int start;
    start = errors;
    run_round(10'd300, 10'd200, 12'd600, 12'd500, 1'b1);
    run_round(10'd300, 10'd200, 12'd400, 12'd300, 1'b0);
    finish_test("overlay", start);
endtask

task automatic test_abort();
    int start;
    start = errors;
    shot_x        = 10'($urandom_range(900, 1));
    shot_y        = 10'($urandom_range(700, 1));
    keeper_active = 1'b1;
    step_cycle();
    keeper_active = 1'b0; // leave before any shot
    step_cycle();
    enemy_shot = 1'b1; // shot after the keeper phase ended
    step_cycle();
    enemy_shot = 1'b0;
    for (int n = 0; n < 40; n++) begin
        if (round_done || end_gk)
            report_error($sformatf("round_done %b end_gk %b after abort", round_done, end_gk));
        step_cycle();
    end
    finish_test("abort", start);
endtask

`endif

//--- verification/tb_gloves_keeper.sv
// tb_gloves_keeper: clock, reset, DUT instance, directed test sequence and closing report
`timescale 1ns/1ns

module tb_gloves_keeper;

    logic        clk;
    logic        rst;
    logic        keeper_active;
    logic        enemy_shot;
    logic [9:0]  shot_x;
    logic [9:0]  shot_y;
    logic [11:0] glove_x;
    logic [11:0] glove_y;
    logic [10:0] vga_in_hcount;
    logic [10:0] vga_in_vcount;
    logic        vga_in_hsync;
    logic        vga_in_vsync;
    logic        vga_in_hblnk;
    logic        vga_in_vblnk;
    logic [11:0] vga_in_rgb;
    logic        is_scored;
    logic        round_done;
    logic        end_gk;
    logic [10:0] vga_out_hcount;
    logic [10:0] vga_out_vcount;
    logic        vga_out_hsync;
    logic        vga_out_vsync;
    logic        vga_out_hblnk;
    logic        vga_out_vblnk;
    logic [11:0] vga_out_rgb;

    int errors;
    int tests_run;
    int tests_failed;

    // short phases: 8 cycle countdown, 6 cycle show
    gloves_keeper_top #(
        .COUNTDOWN_CYCLES(8),
        .SHOW_CYCLES     (6)
    ) UUT (.*);

    `include "gk_tests.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        void'($urandom(32'hac90b0c3));
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        rst           = 1'b1;
        keeper_active = 1'b0;
        enemy_shot    = 1'b0;
        shot_x        = '0;
        shot_y        = '0;
        glove_x       = '0;
        glove_y       = '0;
        vga_in_hcount = '0;
        vga_in_vcount = '0;
        vga_in_hsync  = 1'b0;
        vga_in_vsync  = 1'b0;
        vga_in_hblnk  = 1'b0;
        vga_in_vblnk  = 1'b0;
        vga_in_rgb    = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        test_reset_idle();
        test_goal_round();
        test_save_round();
        test_clamp();
        test_overlay();
        test_abort();

        $display("tests run %0d, tests with errors %0d, total errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
